/* hw/snn_pkg.sv */
package snn_pkg;

  // ====================
  // Sizes
  // ====================
  localparam int NUM_INPUTS  = 16;
  localparam int NUM_OUTPUTS = 4;
  localparam int SUM_W       = 5;
  localparam int MEM_W       = 16;
  localparam int ADDR_W      = 8;

  typedef logic [ADDR_W-1:0] addr_t;

  // ====================
  // Register map
  // ====================
  localparam addr_t REG_CTRL      = 8'h00;
  localparam addr_t REG_CONFIG    = 8'h04;
  localparam addr_t REG_THRESHOLD = 8'h08;
  localparam addr_t REG_STATUS    = 8'h0C;
  localparam addr_t REG_IN_DATA   = 8'h10;
  localparam addr_t REG_OUT_DATA  = 8'h14;
  // Weight masks follow at a 4-byte stride, one per neuron
  localparam addr_t REG_WEIGHT0   = 8'h20;

  typedef enum logic {
    RESET_ZERO     = 1'b0,
    RESET_SUBTRACT = 1'b1
  } reset_mode_t;

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    COMPUTE,
    FIRE
  } seq_state_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    addr_t       paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic [7:0]                             timesteps;
    logic [MEM_W-1:0]                       threshold;
    reset_mode_t                            reset_mode;
    logic [NUM_OUTPUTS-1:0][NUM_INPUTS-1:0] weights;
  } snn_cfg_t;

endpackage

/* hw/snn_apb_regs.sv */
`timescale 1ns/1ns
module snn_apb_regs (
  input  logic                               clk,
  input  logic                               rst_n,
  input  snn_pkg::apb_req_t                  apb_req,
  output snn_pkg::apb_rsp_t                  apb_rsp,
  output snn_pkg::snn_cfg_t                  cfg,
  output logic                               start_pulse,
  output logic                               soft_reset_pulse,
  input  logic                               busy,
  input  logic                               done_pulse,
  input  logic [7:0]                         timestep_cnt,
  output logic                               in_push,
  output logic [snn_pkg::NUM_INPUTS-1:0]     in_wdata,
  input  logic                               in_empty,
  input  logic                               in_full,
  output logic                               out_pop,
  input  logic [snn_pkg::NUM_OUTPUTS-1:0]    out_rdata,
  input  logic                               out_empty,
  input  logic                               out_full
);
  logic                                   access;
  logic                                   wr_en;
  logic                                   rd_en;
  logic                                   sel_ctrl;
  logic                                   sel_config;
  logic                                   sel_thresh;
  logic                                   sel_status;
  logic                                   sel_in;
  logic                                   sel_out;
  logic [snn_pkg::NUM_OUTPUTS-1:0]        weight_sel;
  logic [snn_pkg::NUM_INPUTS-1:0]         weight_rdata;
  logic                                   addr_ok;
  logic                                   done;
  logic [31:0]                            rdata;

  // ====================
  // Address decode
  // ====================
  assign access = apb_req.psel && apb_req.penable;
  assign wr_en  = access && apb_req.pwrite;
  assign rd_en  = access && !apb_req.pwrite;

  assign sel_ctrl   = apb_req.paddr == snn_pkg::REG_CTRL;
  assign sel_config = apb_req.paddr == snn_pkg::REG_CONFIG;
  assign sel_thresh = apb_req.paddr == snn_pkg::REG_THRESHOLD;
  assign sel_status = apb_req.paddr == snn_pkg::REG_STATUS;
  assign sel_in     = apb_req.paddr == snn_pkg::REG_IN_DATA;
  assign sel_out    = apb_req.paddr == snn_pkg::REG_OUT_DATA;

  always_comb begin
    weight_sel   = '0;
    weight_rdata = '0;
    for (int i = 0; i < snn_pkg::NUM_OUTPUTS; i++) begin
      if (apb_req.paddr == snn_pkg::addr_t'(snn_pkg::REG_WEIGHT0 + 4 * i)) begin
        weight_sel[i] = 1'b1;
        weight_rdata  = cfg.weights[i];
      end
    end
  end

  assign addr_ok = sel_ctrl || sel_config || sel_thresh || sel_status ||
                   sel_in || sel_out || (|weight_sel);

  // FIFO ports act in the access phase
  assign in_push  = wr_en && sel_in && !in_full;
  assign in_wdata = apb_req.pwdata[snn_pkg::NUM_INPUTS-1:0];
  assign out_pop  = rd_en && sel_out && !out_empty;

  // ====================
  // Read data and response
  // ====================
  always_comb begin
    rdata = '0;
    if (sel_config) begin
      rdata[7:0] = cfg.timesteps;
      rdata[8]   = cfg.reset_mode;
    end else if (sel_thresh) begin
      rdata[snn_pkg::MEM_W-1:0] = cfg.threshold;
    end else if (sel_status) begin
      rdata[0]    = busy;
      rdata[1]    = done;
      rdata[2]    = in_empty;
      rdata[3]    = in_full;
      rdata[4]    = out_empty;
      rdata[5]    = out_full;
      rdata[15:8] = timestep_cnt;
    end else if (sel_out) begin
      rdata[snn_pkg::NUM_OUTPUTS-1:0] = out_rdata;
    end else if (|weight_sel) begin
      rdata[snn_pkg::NUM_INPUTS-1:0] = weight_rdata;
    end
  end

  assign apb_rsp.prdata  = rdata;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access && (!addr_ok ||
                                      (wr_en && sel_in && in_full) ||
                                      (rd_en && sel_out && out_empty));

  // ====================
  // Registers and command pulses
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg              <= '0;
      start_pulse      <= 1'b0;
      soft_reset_pulse <= 1'b0;
      done             <= 1'b0;
    end else begin
      // A start during a run is dropped
      start_pulse      <= wr_en && sel_ctrl && apb_req.pwdata[0] && !busy;
      soft_reset_pulse <= wr_en && sel_ctrl && apb_req.pwdata[1];

      // Sticky done
      if (done_pulse) begin
        done <= 1'b1;
      end else if (start_pulse) begin
        done <= 1'b0;
      end

      if (wr_en && sel_config) begin
        cfg.timesteps  <= apb_req.pwdata[7:0];
        cfg.reset_mode <= snn_pkg::reset_mode_t'(apb_req.pwdata[8]);
      end
      if (wr_en && sel_thresh) begin
        cfg.threshold <= apb_req.pwdata[snn_pkg::MEM_W-1:0];
      end
      for (int i = 0; i < snn_pkg::NUM_OUTPUTS; i++) begin
        if (wr_en && weight_sel[i]) begin
          cfg.weights[i] <= apb_req.pwdata[snn_pkg::NUM_INPUTS-1:0];
        end
      end
    end
  end

endmodule

/* hw/spike_fifo.sv */
`timescale 1ns/1ns
module spike_fifo #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push,
  input  logic [WIDTH-1:0] wdata,
  input  logic             pop,
  output logic [WIDTH-1:0] rdata,
  output logic             empty,
  output logic             full
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = count == CNT_W'(DEPTH);
  assign empty   = count == '0;
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Show-ahead head word
  assign rdata = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* hw/cim_seq.sv */
`timescale 1ns/1ns
module cim_seq (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start_pulse,
  input  snn_pkg::snn_cfg_t              cfg,
  input  logic                           in_empty,
  output logic                           in_pop,
  input  logic [snn_pkg::NUM_INPUTS-1:0] in_rdata,
  output logic                           macro_start,
  output logic [snn_pkg::NUM_INPUTS-1:0] macro_bitmap,
  input  logic                           macro_done,
  input  logic                           out_full,
  output logic                           lif_update,
  output logic                           busy,
  output logic                           done_pulse,
  output logic [7:0]                     timestep_cnt
);
  snn_pkg::seq_state_t state;
  logic                last_step;

  assign last_step = (timestep_cnt + 8'd1) == cfg.timesteps;
  assign busy      = state != snn_pkg::IDLE;

  // Pop and macro start share one cycle
  assign in_pop       = (state == snn_pkg::FETCH) && !in_empty;
  assign macro_start  = in_pop;
  assign macro_bitmap = in_rdata;

  // Neurons only fire when the output FIFO has room
  assign lif_update = (state == snn_pkg::FIRE) && !out_full;

  // ====================
  // Timestep FSM
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= snn_pkg::IDLE;
      timestep_cnt <= '0;
      done_pulse   <= 1'b0;
    end else begin
      done_pulse <= 1'b0;
      case (state)
        snn_pkg::IDLE: begin
          if (start_pulse) begin
            timestep_cnt <= '0;
            // Zero timesteps finishes at once
            if (cfg.timesteps == 8'd0) begin
              done_pulse <= 1'b1;
            end else begin
              state <= snn_pkg::FETCH;
            end
          end
        end
        snn_pkg::FETCH: begin
          if (in_pop) begin
            state <= snn_pkg::COMPUTE;
          end
        end
        snn_pkg::COMPUTE: begin
          if (macro_done) begin
            state <= snn_pkg::FIRE;
          end
        end
        snn_pkg::FIRE: begin
          if (lif_update) begin
            timestep_cnt <= timestep_cnt + 8'd1;
            if (last_step) begin
              state      <= snn_pkg::IDLE;
              done_pulse <= 1'b1;
            end else begin
              state <= snn_pkg::FETCH;
            end
          end
        end
        default: state <= snn_pkg::IDLE;
      endcase
    end
  end

endmodule

/* hw/cim_macro_model.sv */
`timescale 1ns/1ns
module cim_macro_model #(
  parameter int MACRO_LATENCY = 2
) (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic                                                   start,
  input  logic [snn_pkg::NUM_INPUTS-1:0]                         bitmap,
  input  logic [snn_pkg::NUM_OUTPUTS-1:0][snn_pkg::NUM_INPUTS-1:0] weights,
  output logic                                                   done,
  output logic [snn_pkg::NUM_OUTPUTS-1:0][snn_pkg::SUM_W-1:0]    sums
);
  localparam int CNT_W = $clog2(MACRO_LATENCY + 1);

  logic [CNT_W-1:0]               cnt;
  logic [snn_pkg::NUM_INPUTS-1:0] bitmap_q;

  // Countdown from start raises done on the last count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt      <= '0;
      bitmap_q <= '0;
    end else if (start) begin
      cnt      <= CNT_W'(MACRO_LATENCY);
      bitmap_q <= bitmap;
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  assign done = cnt == CNT_W'(1);

  // Popcount of active word lines per neuron mask
  always_comb begin
    logic [snn_pkg::NUM_INPUTS-1:0] hits;
    for (int i = 0; i < snn_pkg::NUM_OUTPUTS; i++) begin
      hits    = bitmap_q & weights[i];
      sums[i] = '0;
      for (int j = 0; j < snn_pkg::NUM_INPUTS; j++) begin
        sums[i] = sums[i] + {{(snn_pkg::SUM_W - 1){1'b0}}, hits[j]};
      end
    end
  end

endmodule

/* hw/lif_neurons.sv */
`timescale 1ns/1ns
module lif_neurons (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic                                                soft_reset_pulse,
  input  snn_pkg::snn_cfg_t                                   cfg,
  input  logic                                                update,
  input  logic [snn_pkg::NUM_OUTPUTS-1:0][snn_pkg::SUM_W-1:0] sums,
  output logic                                                spike_push,
  output logic [snn_pkg::NUM_OUTPUTS-1:0]                     spikes
);
  logic [snn_pkg::NUM_OUTPUTS-1:0][snn_pkg::MEM_W-1:0] membrane;
  logic [snn_pkg::NUM_OUTPUTS-1:0][snn_pkg::MEM_W-1:0] integ;
  logic [snn_pkg::NUM_OUTPUTS-1:0][snn_pkg::MEM_W-1:0] membrane_next;

  always_comb begin
    logic [snn_pkg::MEM_W:0] wide;
    for (int i = 0; i < snn_pkg::NUM_OUTPUTS; i++) begin
      wide = {1'b0, membrane[i]} +
             {{(snn_pkg::MEM_W + 1 - snn_pkg::SUM_W){1'b0}}, sums[i]};
      // Saturate at the top of the membrane range
      integ[i]  = wide[snn_pkg::MEM_W] ? '1 : wide[snn_pkg::MEM_W-1:0];
      spikes[i] = integ[i] >= cfg.threshold;
      if (!spikes[i]) begin
        membrane_next[i] = integ[i];
      end else if (cfg.reset_mode == snn_pkg::RESET_ZERO) begin
        membrane_next[i] = '0;
      end else begin
        membrane_next[i] = integ[i] - cfg.threshold;
      end
    end
  end

  // Spike vector goes out in the update cycle
  assign spike_push = update;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      membrane <= '0;
    end else if (soft_reset_pulse) begin
      membrane <= '0;
    end else if (update) begin
      membrane <= membrane_next;
    end
  end

endmodule

/* hw/snn_core_top.sv */
`timescale 1ns/1ns
module snn_core_top #(
  parameter int IN_DEPTH      = 8,
  parameter int OUT_DEPTH     = 4,
  parameter int MACRO_LATENCY = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  snn_pkg::apb_req_t apb_req,
  output snn_pkg::apb_rsp_t apb_rsp
);
  snn_pkg::snn_cfg_t                                   cfg;
  logic                                                start_pulse;
  logic                                                soft_reset_pulse;
  logic                                                busy;
  logic                                                done_pulse;
  logic [7:0]                                          timestep_cnt;
  logic                                                in_push;
  logic                                                in_pop;
  logic [snn_pkg::NUM_INPUTS-1:0]                      in_wdata;
  logic [snn_pkg::NUM_INPUTS-1:0]                      in_rdata;
  logic                                                in_empty;
  logic                                                in_full;
  logic                                                out_push;
  logic                                                out_pop;
  logic [snn_pkg::NUM_OUTPUTS-1:0]                     out_wdata;
  logic [snn_pkg::NUM_OUTPUTS-1:0]                     out_rdata;
  logic                                                out_empty;
  logic                                                out_full;
  logic                                                macro_start;
  logic                                                macro_done;
  logic [snn_pkg::NUM_INPUTS-1:0]                      macro_bitmap;
  logic [snn_pkg::NUM_OUTPUTS-1:0][snn_pkg::SUM_W-1:0] macro_sums;
  logic                                                lif_update;

  // ====================
  // Register slave
  // ====================
  snn_apb_regs u_regs (
    .clk              (clk),
    .rst_n            (rst_n),
    .apb_req          (apb_req),
    .apb_rsp          (apb_rsp),
    .cfg              (cfg),
    .start_pulse      (start_pulse),
    .soft_reset_pulse (soft_reset_pulse),
    .busy             (busy),
    .done_pulse       (done_pulse),
    .timestep_cnt     (timestep_cnt),
    .in_push          (in_push),
    .in_wdata         (in_wdata),
    .in_empty         (in_empty),
    .in_full          (in_full),
    .out_pop          (out_pop),
    .out_rdata        (out_rdata),
    .out_empty        (out_empty),
    .out_full         (out_full)
  );

  // ====================
  // Bitmap and spike FIFOs
  // ====================
  spike_fifo #(.WIDTH(snn_pkg::NUM_INPUTS), .DEPTH(IN_DEPTH)) u_in_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (in_push),
    .wdata (in_wdata),
    .pop   (in_pop),
    .rdata (in_rdata),
    .empty (in_empty),
    .full  (in_full)
  );

  spike_fifo #(.WIDTH(snn_pkg::NUM_OUTPUTS), .DEPTH(OUT_DEPTH)) u_out_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (out_push),
    .wdata (out_wdata),
    .pop   (out_pop),
    .rdata (out_rdata),
    .empty (out_empty),
    .full  (out_full)
  );

  // ====================
  // Compute path
  // ====================
  cim_seq u_seq (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_pulse  (start_pulse),
    .cfg          (cfg),
    .in_empty     (in_empty),
    .in_pop       (in_pop),
    .in_rdata     (in_rdata),
    .macro_start  (macro_start),
    .macro_bitmap (macro_bitmap),
    .macro_done   (macro_done),
    .out_full     (out_full),
    .lif_update   (lif_update),
    .busy         (busy),
    .done_pulse   (done_pulse),
    .timestep_cnt (timestep_cnt)
  );

  cim_macro_model #(.MACRO_LATENCY(MACRO_LATENCY)) u_macro (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (macro_start),
    .bitmap  (macro_bitmap),
    .weights (cfg.weights),
    .done    (macro_done),
    .sums    (macro_sums)
  );

  lif_neurons u_lif (
    .clk              (clk),
    .rst_n            (rst_n),
    .soft_reset_pulse (soft_reset_pulse),
    .cfg              (cfg),
    .update           (lif_update),
    .sums             (macro_sums),
    .spike_push       (out_push),
    .spikes           (out_wdata)
  );

endmodule

/* testbench/snn_tb.sv */
`timescale 1ns/1ns
module snn_tb;

  typedef logic [snn_pkg::NUM_OUTPUTS-1:0][snn_pkg::MEM_W-1:0]      mem_vec_t;
  typedef logic [snn_pkg::NUM_OUTPUTS-1:0][snn_pkg::NUM_INPUTS-1:0] mask_vec_t;

  localparam int IN_DEPTH        = 8;
  localparam int OUT_DEPTH       = 4;
  localparam int MACRO_LATENCY   = 2;
  localparam int POLL_LIMIT      = 500;
  // Sum of the timesteps of all runs below
  localparam int TOTAL_STEPS     = 6 + 4 + 4 + 8;
  localparam int WATCHDOG_CYCLES = 200 * TOTAL_STEPS + 2000;

  logic                            clk = 1'b0;
  logic                            rst_n;
  snn_pkg::apb_req_t               apb_req;
  snn_pkg::apb_rsp_t               apb_rsp;

  // Model state and software copy of the configuration
  int                              seed = 23;
  mem_vec_t                        ref_mem;
  mask_vec_t                       w_mask;
  logic [snn_pkg::MEM_W-1:0]       thr;
  snn_pkg::reset_mode_t            mode;
  logic [snn_pkg::NUM_OUTPUTS-1:0] exp_q[$];
  logic [snn_pkg::NUM_OUTPUTS-1:0] got_q[$];

  snn_core_top #(
    .IN_DEPTH      (IN_DEPTH),
    .OUT_DEPTH     (OUT_DEPTH),
    .MACRO_LATENCY (MACRO_LATENCY)
  ) dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  always #4 clk = ~clk;

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "check failed");
  endtask

  // ====================
  // Reference model
  // ====================
  function automatic logic [snn_pkg::NUM_OUTPUTS-1:0] lif_ref(
    input  logic [snn_pkg::NUM_INPUTS-1:0] bitmap,
    input  mask_vec_t                      weights,
    input  logic [snn_pkg::MEM_W-1:0]      threshold,
    input  snn_pkg::reset_mode_t           reset_mode,
    input  mem_vec_t                       mem_in,
    output mem_vec_t                       mem_out
  );
    logic [snn_pkg::NUM_OUTPUTS-1:0] spk;
    int                              sum;
    int                              acc;
    for (int n = 0; n < snn_pkg::NUM_OUTPUTS; n++) begin
      sum = 0;
      for (int b = 0; b < snn_pkg::NUM_INPUTS; b++) begin
        if (bitmap[b] && weights[n][b]) begin
          sum++;
        end
      end
      acc = int'(mem_in[n]) + sum;
      if (acc > (1 << snn_pkg::MEM_W) - 1) begin
        acc = (1 << snn_pkg::MEM_W) - 1;
      end
      spk[n] = acc >= int'(threshold);
      if (!spk[n]) begin
        mem_out[n] = acc[snn_pkg::MEM_W-1:0];
      end else if (reset_mode == snn_pkg::RESET_ZERO) begin
        mem_out[n] = '0;
      end else begin
        acc        = acc - int'(threshold);
        mem_out[n] = acc[snn_pkg::MEM_W-1:0];
      end
    end
    return spk;
  endfunction

  function automatic logic [31:0] status_bits(
    input logic       busy,
    input logic       done,
    input logic       in_empty,
    input logic       in_full,
    input logic       out_empty,
    input logic       out_full,
    input logic [7:0] cnt
  );
    logic [31:0] v;
    v       = '0;
    v[0]    = busy;
    v[1]    = done;
    v[2]    = in_empty;
    v[3]    = in_full;
    v[4]    = out_empty;
    v[5]    = out_full;
    v[15:8] = cnt;
    return v;
  endfunction

  function automatic snn_pkg::addr_t weight_addr(input int i);
    return snn_pkg::addr_t'(snn_pkg::REG_WEIGHT0 + 4 * i);
  endfunction

  // ====================
  // APB tasks
  // ====================
  task automatic apb_write(input snn_pkg::addr_t addr, input logic [31:0] data,
                           output logic err);
    @(posedge clk);
    #1;
    apb_req.psel   = 1'b1;
    apb_req.pwrite = 1'b1;
    apb_req.paddr  = addr;
    apb_req.pwdata = data;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    #2;
    err = apb_rsp.pslverr;
    assert (apb_rsp.pready) else report_fail("pready was low in a write access phase");
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic apb_read(input snn_pkg::addr_t addr, output logic [31:0] data,
                          output logic err);
    @(posedge clk);
    #1;
    apb_req.psel   = 1'b1;
    apb_req.pwrite = 1'b0;
    apb_req.paddr  = addr;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    // Access phase response settles well before the next edge
    #2;
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    assert (apb_rsp.pready) else report_fail("pready was low in a read access phase");
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic write_reg(input snn_pkg::addr_t addr, input logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    assert (!err) else report_fail($sformatf("write to 0x%h got an error response", addr));
  endtask

  task automatic read_reg(input snn_pkg::addr_t addr, output logic [31:0] data);
    logic err;
    apb_read(addr, data, err);
    assert (!err) else report_fail($sformatf("read of 0x%h got an error response", addr));
  endtask

  task automatic check_reg(input snn_pkg::addr_t addr, input logic [31:0] exp,
                           input string name);
    logic [31:0] d;
    read_reg(addr, d);
    assert (d == exp) else report_fail($sformatf("error %s got 0x%h exp 0x%h", name, d, exp));
  endtask

  task automatic check_status(input logic [31:0] mask, input logic [31:0] exp);
    logic [31:0] d;
    read_reg(snn_pkg::REG_STATUS, d);
    assert ((d & mask) == exp)
      else report_fail($sformatf("error status got 0x%h exp 0x%h", d & mask, exp));
  endtask

  task automatic poll_status(input logic [31:0] mask, input logic [31:0] value,
                             input string what);
    logic [31:0] d;
    int          polls;
    polls = 0;
    read_reg(snn_pkg::REG_STATUS, d);
    while ((d & mask) != value) begin
      polls++;
      assert (polls < POLL_LIMIT) else report_fail($sformatf("timed out waiting for %s", what));
      read_reg(snn_pkg::REG_STATUS, d);
    end
  endtask

  // ====================
  // Stimulus helpers
  // ====================
  task automatic set_cfg(input logic [7:0] steps, input snn_pkg::reset_mode_t m,
                         input logic [snn_pkg::MEM_W-1:0] t);
    mode = m;
    thr  = t;
    write_reg(snn_pkg::REG_CONFIG, {23'h0, m, steps});
    write_reg(snn_pkg::REG_THRESHOLD, {16'h0, t});
  endtask

  task automatic set_random_weights();
    for (int i = 0; i < snn_pkg::NUM_OUTPUTS; i++) begin
      w_mask[i] = 16'($random(seed));
      write_reg(weight_addr(i), {16'h0, w_mask[i]});
    end
  endtask

  // Pushes one bitmap and queues the spike vector it should produce
  task automatic push_bitmap();
    logic [snn_pkg::NUM_INPUTS-1:0] bm;
    mem_vec_t                       next_mem;
    bm = 16'($random(seed));
    write_reg(snn_pkg::REG_IN_DATA, {16'h0, bm});
    exp_q.push_back(lif_ref(bm, w_mask, thr, mode, ref_mem, next_mem));
    ref_mem = next_mem;
  endtask

  task automatic read_out();
    logic [31:0] d;
    read_reg(snn_pkg::REG_OUT_DATA, d);
    got_q.push_back(d[snn_pkg::NUM_OUTPUTS-1:0]);
  endtask

  task automatic run_and_drain(input int n);
    logic [31:0] d;
    int          polls;
    logic        finished;
    polls    = 0;
    finished = 1'b0;
    while (!finished) begin
      read_reg(snn_pkg::REG_STATUS, d);
      if (d[1] && d[4]) begin
        finished = 1'b1;
      end else begin
        if (!d[4]) begin
          read_out();
        end
        polls++;
        assert (polls < POLL_LIMIT) else report_fail("run did not finish while draining outputs");
      end
    end
    check_status(status_bits(1, 0, 0, 0, 0, 0, 8'hFF), status_bits(0, 0, 0, 0, 0, 0, 8'(n)));
    assert (exp_q.size() == 0) else report_fail("expected spike vectors were never read");
  endtask

  // Compare read-back spike vectors in order
  always @(negedge clk) begin : compare_outputs
    logic [snn_pkg::NUM_OUTPUTS-1:0] got;
    logic [snn_pkg::NUM_OUTPUTS-1:0] exp;
    while (got_q.size() > 0) begin
      got = got_q.pop_front();
      assert (exp_q.size() > 0) else report_fail("output read with no expected vector left");
      exp = exp_q.pop_front();
      assert (got == exp)
        else report_fail($sformatf("error out_data got 0x%h exp 0x%h", got, exp));
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

  // ====================
  // Test sequence
  // ====================
  initial begin : test_seq
    logic [31:0] d;
    logic        err;
    apb_req = '0;
    rst_n   = 1'b0;
    ref_mem = '0;
    w_mask  = '0;
    thr     = '0;
    mode    = snn_pkg::RESET_ZERO;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Reset state
    check_status(32'hFFFF_FFFF, status_bits(0, 0, 1, 0, 1, 0, 8'h00));
    check_reg(snn_pkg::REG_CONFIG, 32'h0, "config");
    check_reg(snn_pkg::REG_THRESHOLD, 32'h0, "threshold");
    for (int i = 0; i < snn_pkg::NUM_OUTPUTS; i++) begin
      check_reg(weight_addr(i), 32'h0, "weight");
    end

    // Register read-back drops the upper bits
    write_reg(snn_pkg::REG_CONFIG, 32'hFFFF_FFFF);
    check_reg(snn_pkg::REG_CONFIG, 32'h0000_01FF, "config");
    write_reg(snn_pkg::REG_CONFIG, 32'h0000_00A5);
    check_reg(snn_pkg::REG_CONFIG, 32'h0000_00A5, "config");
    write_reg(snn_pkg::REG_THRESHOLD, 32'hDEAD_BEEF);
    check_reg(snn_pkg::REG_THRESHOLD, 32'h0000_BEEF, "threshold");
    for (int i = 0; i < snn_pkg::NUM_OUTPUTS; i++) begin
      write_reg(weight_addr(i), {16'hABCD, 16'(32'h1111 * (i + 1))});
      check_reg(weight_addr(i), {16'h0, 16'(32'h1111 * (i + 1))}, "weight");
    end

    // Subtract reset run
    set_random_weights();
    set_cfg(8'd6, snn_pkg::RESET_SUBTRACT, 16'd5);
    repeat (6) push_bitmap();
    write_reg(snn_pkg::REG_CTRL, 32'h1);
    run_and_drain(6);
    check_status(status_bits(0, 0, 0, 0, 1, 0, 8'h00), status_bits(0, 0, 0, 0, 1, 0, 8'h00));

    // Zero reset with membranes carried over from the last run
    set_cfg(8'd4, snn_pkg::RESET_ZERO, 16'd9);
    repeat (4) push_bitmap();
    write_reg(snn_pkg::REG_CTRL, 32'h1);
    run_and_drain(4);

    // Soft reset clears the membranes
    write_reg(snn_pkg::REG_CTRL, 32'h2);
    ref_mem = '0;
    repeat (4) push_bitmap();
    write_reg(snn_pkg::REG_CTRL, 32'h1);
    run_and_drain(4);

    // Back-pressure on both FIFOs
    set_random_weights();
    set_cfg(8'd8, snn_pkg::RESET_SUBTRACT, 16'd3);
    repeat (2) push_bitmap();
    write_reg(snn_pkg::REG_CTRL, 32'h1);
    poll_status(status_bits(0, 0, 1, 0, 0, 0, 8'hFF), status_bits(0, 0, 1, 0, 0, 0, 8'd2),
                "stall on empty input");
    repeat (10) @(posedge clk);
    check_status(status_bits(1, 1, 0, 0, 0, 0, 8'hFF), status_bits(1, 0, 0, 0, 0, 0, 8'd2));
    repeat (6) push_bitmap();
    poll_status(status_bits(0, 0, 0, 0, 0, 1, 8'h00), status_bits(0, 0, 0, 0, 0, 1, 8'h00),
                "full output FIFO");
    repeat (20) @(posedge clk);
    check_status(status_bits(1, 1, 0, 0, 0, 1, 8'hFF), status_bits(1, 0, 0, 0, 0, 1, 8'd4));
    run_and_drain(8);

    // Error responses
    apb_read(8'h18, d, err);
    assert (err) else report_fail("no error response for a read of unmapped address 0x18");
    apb_write(8'h30, 32'h1, err);
    assert (err) else report_fail("no error response for a write to unmapped address 0x30");
    apb_read(snn_pkg::REG_OUT_DATA, d, err);
    assert (err) else report_fail("no error response for a read of the empty output FIFO");
    for (int i = 0; i < IN_DEPTH; i++) begin
      write_reg(snn_pkg::REG_IN_DATA, 32'(i));
    end
    apb_write(snn_pkg::REG_IN_DATA, 32'h55, err);
    assert (err) else report_fail("no error response for a push into the full input FIFO");
    check_status(status_bits(1, 0, 1, 1, 0, 0, 8'h00), status_bits(0, 0, 0, 1, 0, 0, 8'h00));

    repeat (2) @(posedge clk);
    if (exp_q.size() != 0 || got_q.size() != 0) begin
      $display("spike vectors left unchecked at the end of the run");
      $display("Simulation failed");
      $fatal(1, "unchecked outputs");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

/* sim.f */
hw/snn_pkg.sv
hw/snn_apb_regs.sv
hw/spike_fifo.sv
hw/cim_seq.sv
hw/cim_macro_model.sv
hw/lif_neurons.sv
hw/snn_core_top.sv
testbench/snn_tb.sv

/* Makefile */
SRCS := $(wildcard hw/*.sv) $(wildcard testbench/*.sv)

.PHONY: run clean

obj_dir/snn_tb: sim.f $(SRCS)
	verilator --binary --timing --assert -f sim.f --top-module snn_tb -o snn_tb

run: obj_dir/snn_tb
	./obj_dir/snn_tb | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
